//--- fetch_pkg.sv
// Fetch stage shared types
`default_nettype none

package fetch_pkg;

    ////////////////////
    // Address map

    typedef logic [31:0] addr_t;

    localparam addr_t LOCAL_BASE = 32'h0000_0000;
    localparam addr_t BUS_BASE   = 32'h8000_0000;

    // Target of one fetch request
    typedef enum logic [1:0] {
        UNIT_LOCAL = 2'd0,
        UNIT_BUS   = 2'd1,
        UNIT_NONE  = 2'd2
    } unit_sel_t;

    ////////////////////
    // Fetch bookkeeping

    // One entry per request in flight
    typedef struct packed {
        addr_t     pc;
        unit_sel_t sel;
        logic      fault;
    } fetch_attr_t;

    typedef struct packed {
        addr_t       pc;
        logic [31:0] instr;
        logic        fault;
    } fetch_packet_t;

    ////////////////////
    // Memory sub-unit ports

    // Word index relative to the region base
    typedef struct packed {
        logic        req;
        logic [29:0] index;
    } unit_req_t;

    typedef struct packed {
        logic        ready;
        logic        data_valid;
        logic [31:0] data;
    } unit_rsp_t;

    // Preload port shared by both memories
    typedef struct packed {
        logic        we;
        addr_t       addr;
        logic [31:0] data;
    } mem_write_t;

endpackage

`default_nettype wire

//--- fetch_attr_fifo.sv
// Fetch attribute FIFO
`timescale 1ns/100ps
`default_nettype none

module fetch_attr_fifo #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  logic                   pop,
    input  fetch_pkg::fetch_attr_t data_in,
    output fetch_pkg::fetch_attr_t data_out,
    output logic                   valid,
    output logic                   full
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    fetch_pkg::fetch_attr_t entries [FIFO_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;

    // Entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // Head shown without a read cycle
    assign data_out = entries[rd_ptr];
    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

//--- ilocal_mem.sv
// Local instruction memory
`timescale 1ns/100ps
`default_nettype none

module ilocal_mem #(
    parameter int LOCAL_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    input  fetch_pkg::unit_req_t  req,
    output fetch_pkg::unit_rsp_t  rsp,
    input  fetch_pkg::mem_write_t load
);

    localparam int IDX_W = (LOCAL_WORDS > 1) ? $clog2(LOCAL_WORDS) : 1;
    localparam fetch_pkg::addr_t LOCAL_BYTES = fetch_pkg::addr_t'(LOCAL_WORDS * 4);

    logic [31:0]      mem [LOCAL_WORDS];
    fetch_pkg::addr_t load_off;
    logic             load_hit;
    logic [31:0]      rd_data;
    logic             rd_valid;

    assign load_off = load.addr - fetch_pkg::LOCAL_BASE;
    assign load_hit = load.we & (load_off < LOCAL_BYTES);

    // Preload and registered read
    always_ff @(posedge clk) begin
        if (load_hit) begin
            mem[load_off[IDX_W+1:2]] <= load.data;
        end
        if (req.req) begin
            rd_data <= mem[req.index[IDX_W-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= req.req;
        end
    end

    assign rsp.ready      = 1'b1;
    assign rsp.data_valid = rd_valid;
    assign rsp.data       = rd_data;

endmodule

`default_nettype wire

//--- ibus_mem.sv
// Bus memory model with wait states
`timescale 1ns/100ps
`default_nettype none

module ibus_mem #(
    parameter int BUS_WORDS   = 256,
    parameter int WAIT_STATES = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  fetch_pkg::unit_req_t  req,
    output fetch_pkg::unit_rsp_t  rsp,
    input  fetch_pkg::mem_write_t load
);

    localparam int IDX_W = (BUS_WORDS > 1) ? $clog2(BUS_WORDS) : 1;
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
    localparam fetch_pkg::addr_t BUS_BYTES = fetch_pkg::addr_t'(BUS_WORDS * 4);

    logic [31:0]      mem [BUS_WORDS];
    fetch_pkg::addr_t load_off;
    logic             load_hit;
    logic [29:0]      index_q;
    logic             active;
    logic [CNT_W-1:0] wait_cnt;
    logic             busy;

    assign load_off = load.addr - fetch_pkg::BUS_BASE;
    assign load_hit = load.we & (load_off < BUS_BYTES);

    always_ff @(posedge clk) begin
        if (load_hit) begin
            mem[load_off[IDX_W+1:2]] <= load.data;
        end
        if (req.req) begin
            index_q <= req.index;
        end
    end

    ////////////////////
    // Wait-state counter

    // Counts down the wait cycles and returns data at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            wait_cnt <= '0;
        end else if (req.req) begin
            active   <= 1'b1;
            wait_cnt <= CNT_W'(WAIT_STATES);
        end else if (active) begin
            if (wait_cnt == '0) begin
                active <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    assign busy = active & (wait_cnt != '0);

    assign rsp.ready      = ~busy;
    assign rsp.data_valid = active & (wait_cnt == '0);
    assign rsp.data       = mem[index_q[IDX_W-1:0]];

endmodule

`default_nettype wire

//--- fetch_control.sv
// Fetch controller
`timescale 1ns/100ps
`default_nettype none

module fetch_control #(
    parameter int                LOCAL_WORDS = 256,
    parameter int                BUS_WORDS   = 256,
    parameter fetch_pkg::addr_t  RESET_VEC   = fetch_pkg::LOCAL_BASE,
    parameter int                FIFO_DEPTH  = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     hold,
    input  logic                     redirect,
    input  fetch_pkg::addr_t         redirect_pc,
    output fetch_pkg::unit_req_t     local_req,
    output fetch_pkg::unit_req_t     bus_req,
    input  fetch_pkg::unit_rsp_t     local_rsp,
    input  fetch_pkg::unit_rsp_t     bus_rsp,
    output logic                     attr_push,
    output fetch_pkg::fetch_attr_t   attr_in,
    output logic                     attr_pop,
    input  fetch_pkg::fetch_attr_t   attr_head,
    input  logic                     attr_valid,
    input  logic                     attr_full,
    output logic                     fetch_valid,
    output fetch_pkg::fetch_packet_t fetch_packet
);

    localparam fetch_pkg::addr_t LOCAL_BYTES = fetch_pkg::addr_t'(LOCAL_WORDS * 4);
    localparam fetch_pkg::addr_t BUS_BYTES   = fetch_pkg::addr_t'(BUS_WORDS * 4);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    fetch_pkg::addr_t     pc;
    fetch_pkg::addr_t     local_off;
    fetch_pkg::addr_t     bus_off;
    fetch_pkg::unit_sel_t unit_sel;
    logic                 issue;
    logic                 complete;
    logic                 fault_pending;
    logic [CNT_W-1:0]     inflight_count;
    logic [CNT_W-1:0]     inflight_next;
    logic [CNT_W-1:0]     flush_count;
    logic [31:0]          head_data;

    ////////////////////
    // PC and region decode

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VEC;
        end else if (redirect) begin
            pc <= {redirect_pc[31:2], 2'b00};
        end else if (issue) begin
            pc <= pc + 32'd4;
        end
    end

    assign local_off = pc - fetch_pkg::LOCAL_BASE;
    assign bus_off   = pc - fetch_pkg::BUS_BASE;

    always_comb begin
        if (local_off < LOCAL_BYTES) begin
            unit_sel = fetch_pkg::UNIT_LOCAL;
        end else if (bus_off < BUS_BYTES) begin
            unit_sel = fetch_pkg::UNIT_BUS;
        end else begin
            unit_sel = fetch_pkg::UNIT_NONE;
        end
    end

    ////////////////////
    // Issue

    // Both units must be idle so responses come back in order
    assign issue = ~hold & ~fault_pending & ~attr_full & local_rsp.ready & bus_rsp.ready
                 & ~redirect;

    assign local_req.req   = issue & (unit_sel == fetch_pkg::UNIT_LOCAL);
    assign local_req.index = local_off[31:2];
    assign bus_req.req     = issue & (unit_sel == fetch_pkg::UNIT_BUS);
    assign bus_req.index   = bus_off[31:2];

    assign attr_push     = issue;
    assign attr_in.pc    = pc;
    assign attr_in.sel   = unit_sel;
    assign attr_in.fault = (unit_sel == fetch_pkg::UNIT_NONE);

    // Stop after an unmapped address until redirected
    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            fault_pending <= 1'b0;
        end else if (issue && unit_sel == fetch_pkg::UNIT_NONE) begin
            fault_pending <= 1'b1;
        end
    end

    ////////////////////
    // Completion and flush

    always_comb begin
        case (attr_head.sel)
            fetch_pkg::UNIT_LOCAL: begin
                complete  = attr_valid & local_rsp.data_valid;
                head_data = local_rsp.data;
            end
            fetch_pkg::UNIT_BUS: begin
                complete  = attr_valid & bus_rsp.data_valid;
                head_data = bus_rsp.data;
            end
            default: begin
                complete  = attr_valid;
                head_data = '0;
            end
        endcase
    end

    assign attr_pop = complete;

    assign inflight_next = inflight_count + CNT_W'(attr_push) - CNT_W'(attr_pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_count <= '0;
        end else begin
            inflight_count <= inflight_next;
        end
    end

    // Everything still in flight after a redirect is stale
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_count <= '0;
        end else if (redirect) begin
            flush_count <= inflight_next;
        end else if (complete && flush_count != '0) begin
            flush_count <= flush_count - 1'b1;
        end
    end

    assign fetch_valid        = complete & (flush_count == '0);
    assign fetch_packet.pc    = attr_head.pc;
    assign fetch_packet.instr = attr_head.fault ? 32'd0 : head_data;
    assign fetch_packet.fault = attr_head.fault;

endmodule

`default_nettype wire

//--- fetch_top.sv
// Instruction fetch stage top level
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
    parameter int               LOCAL_WORDS = 256,
    parameter int               BUS_WORDS   = 256,
    parameter int               WAIT_STATES = 3,
    parameter fetch_pkg::addr_t RESET_VEC   = fetch_pkg::LOCAL_BASE,
    parameter int               FIFO_DEPTH  = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     hold,
    input  logic                     redirect,
    input  fetch_pkg::addr_t         redirect_pc,
    input  fetch_pkg::mem_write_t    load,
    output logic                     fetch_valid,
    output fetch_pkg::fetch_packet_t fetch_packet
);

    fetch_pkg::unit_req_t   local_req;
    fetch_pkg::unit_req_t   bus_req;
    fetch_pkg::unit_rsp_t   local_rsp;
    fetch_pkg::unit_rsp_t   bus_rsp;
    logic                   attr_push;
    logic                   attr_pop;
    fetch_pkg::fetch_attr_t attr_in;
    fetch_pkg::fetch_attr_t attr_head;
    logic                   attr_valid;
    logic                   attr_full;

    fetch_control #(
        .LOCAL_WORDS (LOCAL_WORDS),
        .BUS_WORDS   (BUS_WORDS),
        .RESET_VEC   (RESET_VEC),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) u_control (
        .clk          (clk),
        .rst          (rst),
        .hold         (hold),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .local_req    (local_req),
        .bus_req      (bus_req),
        .local_rsp    (local_rsp),
        .bus_rsp      (bus_rsp),
        .attr_push    (attr_push),
        .attr_in      (attr_in),
        .attr_pop     (attr_pop),
        .attr_head    (attr_head),
        .attr_valid   (attr_valid),
        .attr_full    (attr_full),
        .fetch_valid  (fetch_valid),
        .fetch_packet (fetch_packet)
    );

    fetch_attr_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_attr_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (attr_push),
        .pop      (attr_pop),
        .data_in  (attr_in),
        .data_out (attr_head),
        .valid    (attr_valid),
        .full     (attr_full)
    );

    // Load port goes to both memories and each checks its own region
    ilocal_mem #(
        .LOCAL_WORDS (LOCAL_WORDS)
    ) u_local_mem (
        .clk  (clk),
        .rst  (rst),
        .req  (local_req),
        .rsp  (local_rsp),
        .load (load)
    );

    ibus_mem #(
        .BUS_WORDS   (BUS_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) u_bus_mem (
        .clk  (clk),
        .rst  (rst),
        .req  (bus_req),
        .rsp  (bus_rsp),
        .load (load)
    );

endmodule

`default_nettype wire

//--- tb_fetch.sv
// Fetch stage testbench
`timescale 1ns/100ps
`default_nettype none

module tb_fetch;

    // Mirrors the default parameters of fetch_top
    localparam int               LOCAL_WORDS = 256;
    localparam int               BUS_WORDS   = 256;
    localparam int               WAIT_STATES = 3;
    localparam int               FIFO_DEPTH  = 2;
    localparam fetch_pkg::addr_t RESET_VEC   = fetch_pkg::LOCAL_BASE;

    localparam int RATE_OFF   = 0;
    localparam int RATE_LOCAL = 1;
    localparam int RATE_BUS   = 2;

    logic                     clk;
    logic                     rst;
    logic                     hold;
    logic                     redirect;
    fetch_pkg::addr_t         redirect_pc;
    fetch_pkg::mem_write_t    load;
    logic                     fetch_valid;
    fetch_pkg::fetch_packet_t fetch_packet;

    integer           seed;
    logic [31:0]      local_copy [LOCAL_WORDS];
    logic [31:0]      bus_copy [BUS_WORDS];
    fetch_pkg::addr_t exp_pc;
    logic [31:0]      exp_instr;
    logic             exp_fault;
    int               gap;
    int               rate_mode;
    int               held_pkts;
    logic             fault_seen;

    fetch_top dut (
        .clk          (clk),
        .rst          (rst),
        .hold         (hold),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .load         (load),
        .fetch_valid  (fetch_valid),
        .fetch_packet (fetch_packet)
    );

    always #50 clk = ~clk;

    ////////////////////
    // Reference model

    function automatic logic in_local(input fetch_pkg::addr_t addr);
        return (addr - fetch_pkg::LOCAL_BASE) < fetch_pkg::addr_t'(LOCAL_WORDS * 4);
    endfunction

    function automatic logic in_bus(input fetch_pkg::addr_t addr);
        return (addr - fetch_pkg::BUS_BASE) < fetch_pkg::addr_t'(BUS_WORDS * 4);
    endfunction

    function automatic logic [31:0] expected_word(input fetch_pkg::addr_t addr);
        fetch_pkg::addr_t off_local;
        fetch_pkg::addr_t off_bus;
        off_local = addr - fetch_pkg::LOCAL_BASE;
        off_bus   = addr - fetch_pkg::BUS_BASE;
        if (in_local(addr)) begin
            return local_copy[int'(off_local >> 2)];
        end else if (in_bus(addr)) begin
            return bus_copy[int'(off_bus >> 2)];
        end
        return 32'd0;
    endfunction

    always_comb begin
        exp_fault = !(in_local(exp_pc) || in_bus(exp_pc));
        exp_instr = expected_word(exp_pc);
    end

    // Expected PC, packet spacing, hold and fault bookkeeping
    always @(posedge clk) begin
        if (rst) begin
            exp_pc     <= RESET_VEC;
            gap        <= 1000;
            held_pkts  <= 0;
            fault_seen <= 1'b0;
        end else begin
            gap <= gap + 1;
            if (fetch_valid) begin
                exp_pc <= exp_pc + 32'd4;
                gap    <= 1;
            end
            if (redirect) begin
                exp_pc <= redirect_pc;
            end
            if (!hold) begin
                held_pkts <= 0;
            end else if (fetch_valid) begin
                held_pkts <= held_pkts + 1;
            end
            if (redirect) begin
                fault_seen <= 1'b0;
            end else if (fetch_valid && fetch_packet.fault) begin
                fault_seen <= 1'b1;
            end
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    ////////////////////
    // Packet checks

    pc_order: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |-> fetch_packet.pc == exp_pc)
        else fail_run($sformatf("Mismatch at %0t ns: packet pc %h, expected %h",
                                $time, fetch_packet.pc, exp_pc));

    fault_flag: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |-> fetch_packet.fault == exp_fault)
        else fail_run($sformatf("Mismatch at %0t ns: fault %b at pc %h, expected %b",
                                $time, fetch_packet.fault, fetch_packet.pc, exp_fault));

    instr_word: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && !fetch_packet.fault |-> fetch_packet.instr == exp_instr)
        else fail_run($sformatf("Mismatch at %0t ns: instr %h at pc %h, expected %h",
                                $time, fetch_packet.instr, fetch_packet.pc, exp_instr));

    fault_instr: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && fetch_packet.fault |-> fetch_packet.instr == 32'd0)
        else fail_run($sformatf("Mismatch at %0t ns: fault packet instr %h, expected zero",
                                $time, fetch_packet.instr));

    local_rate: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && rate_mode == RATE_LOCAL |-> gap == 1)
        else fail_run("Local fetches did not deliver one packet per cycle");

    bus_rate: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && rate_mode == RATE_BUS |-> gap >= WAIT_STATES + 1)
        else fail_run("Two bus packets arrived closer than the bus latency allows");

    after_fault: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |-> !fault_seen)
        else fail_run("A packet arrived after a fault packet without a redirect");

    hold_limit: assert property (@(posedge clk) disable iff (rst)
        fetch_valid && hold |-> held_pkts < FIFO_DEPTH)
        else fail_run("More packets than the FIFO depth arrived after hold was raised");

    ////////////////////
    // Stimulus tasks

    task automatic preload_memories();
        int          i;
        logic [31:0] word;
        for (i = 0; i < LOCAL_WORDS; i++) begin
            word          = $random(seed);
            local_copy[i] = word;
            @(posedge clk);
            load.we   <= 1'b1;
            load.addr <= fetch_pkg::LOCAL_BASE + fetch_pkg::addr_t'(i * 4);
            load.data <= word;
        end
        for (i = 0; i < BUS_WORDS; i++) begin
            word        = $random(seed);
            bus_copy[i] = word;
            @(posedge clk);
            load.we   <= 1'b1;
            load.addr <= fetch_pkg::BUS_BASE + fetch_pkg::addr_t'(i * 4);
            load.data <= word;
        end
        @(posedge clk);
        load.we <= 1'b0;
    endtask

    // Counts packets seen at each falling edge
    task automatic wait_packets(input int count, input int limit, input string what);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < count && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (fetch_valid) begin
                seen++;
            end
        end
        if (seen < count) begin
            fail_run($sformatf("Timeout after %0d cycles waiting for %s", limit, what));
        end
    endtask

    task automatic redirect_to(input fetch_pkg::addr_t target);
        @(posedge clk);
        rate_mode   <= RATE_OFF;
        redirect    <= 1'b1;
        redirect_pc <= target;
        @(posedge clk);
        redirect <= 1'b0;
    endtask

    task automatic set_rate(input int mode);
        @(posedge clk);
        rate_mode <= mode;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) @(negedge clk);
    endtask

    ////////////////////
    // Test sequence

    initial begin
        seed        = 44;
        clk         = 1'b0;
        rst         = 1'b1;
        hold        = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        load        = '0;
        rate_mode   = RATE_OFF;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        preload_memories();

        // Local run from the reset vector
        @(posedge clk);
        hold <= 1'b0;
        wait_packets(1, 20, "the first packet from the reset vector");
        set_rate(RATE_LOCAL);
        wait_packets(20, 40, "the local packet run");

        // Bus region run
        redirect_to(fetch_pkg::BUS_BASE + 32'h40);
        wait_packets(1, 20, "the first bus packet");
        set_rate(RATE_BUS);
        wait_packets(8, 8 * (WAIT_STATES + 1) + 20, "the bus packet run");

        // Redirect while a bus request is still in flight
        redirect_to(fetch_pkg::LOCAL_BASE + 32'h200);
        wait_packets(1, 20, "the first packet after the in-flight redirect");
        set_rate(RATE_LOCAL);
        wait_packets(10, 30, "the local run after the in-flight redirect");

        // Unmapped address gives one fault packet and then silence
        redirect_to(32'h4000_0000);
        wait_packets(1, 20, "the fault packet");
        idle_cycles(40);
        redirect_to(fetch_pkg::LOCAL_BASE + 32'h80);
        wait_packets(5, 30, "packets after leaving the fault");

        // Hold lets only in-flight packets through
        @(posedge clk);
        hold      <= 1'b1;
        rate_mode <= RATE_OFF;
        idle_cycles(20);
        @(posedge clk);
        hold <= 1'b0;
        wait_packets(1, 20, "the first packet after hold fell");
        set_rate(RATE_LOCAL);
        wait_packets(8, 30, "the local run after hold fell");

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
fetch_pkg.sv
fetch_attr_fifo.sv
ilocal_mem.sv
ibus_mem.sv
fetch_control.sv
fetch_top.sv
tb_fetch.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module tb_fetch -f src.f

run: compile
	./obj_dir/Vtb_fetch | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
